// File: mbus_pkg.sv
/*
 * shared widths, isolation levels and sequencer states for the layer
 * a control level at io_hold means isolated or switched off
 */
package mbus_pkg;

	typedef logic [7:0]  addr_t;	// bus short address
	typedef logic [31:0] data_t;	// one payload word

	localparam logic io_hold    = 1'b0;	// during sleep
	localparam logic io_release = 1'b1;	// during wake-up

	// wake steps release one output each, sleep steps withdraw them again
	typedef enum logic [3:0] {
		asleep,
		iso_on_step,	// releases iso_sleep
		pwr_on_step,	// releases power_on
		clk_on_step,	// releases release_clk
		rst_on_step,	// releases release_rst
		bc_on_step,	// releases release_iso_bc
		active,
		rst_off_step,	// withdraws release_rst
		clk_off_step,	// withdraws release_clk
		pwr_off_step,	// withdraws power_on
		iso_off_step	// withdraws iso_sleep
	} seq_state_t;

endpackage

// File: mbus_power_seq.sv
/*
 * always-on power sequencer for one layer
 * wake_req is only seen while asleep, sleep_req only while active
 * every step dwells STEP_CYCLES cycles; power and clock are plain levels
 */
module mbus_power_seq
	import mbus_pkg::*;
#(
	parameter int STEP_CYCLES = 2
)(
	input  logic clk,
	input  logic rst_n,
	input  logic wake_req,
	input  logic sleep_req,
	output logic iso_sleep,
	output logic power_on,
	output logic release_clk,
	output logic release_rst,
	output logic release_iso_bc,
	output logic layer_active
);

	localparam int CNT_W = $clog2(STEP_CYCLES + 1);

	seq_state_t state;
	logic [CNT_W-1:0] dwell;
	logic step_done;

	assign step_done = (dwell == CNT_W'(STEP_CYCLES - 1));
	assign layer_active = (state == active);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state          <= asleep;
			dwell          <= '0;
			iso_sleep      <= io_hold;
			power_on       <= io_hold;
			release_clk    <= io_hold;
			release_rst    <= io_hold;
			release_iso_bc <= io_hold;
		end
		else
		begin
			case (state)
				asleep:
				begin
					dwell <= '0;
					if (wake_req)
						state <= iso_on_step;
				end
				active:
				begin
					dwell <= '0;
					if (sleep_req)
					begin
						release_iso_bc <= io_hold;	// bus side isolates at once
						state          <= rst_off_step;
					end
				end
				default:
				begin
					if (!step_done)
						dwell <= dwell + 1'b1;
					else
					begin
						dwell <= '0;
						case (state)
							iso_on_step:
							begin
								iso_sleep <= io_release;
								state     <= pwr_on_step;
							end
							pwr_on_step:
							begin
								power_on <= io_release;
								state    <= clk_on_step;
							end
							clk_on_step:
							begin
								release_clk <= io_release;
								state       <= rst_on_step;
							end
							rst_on_step:
							begin
								release_rst <= io_release;
								state       <= bc_on_step;
							end
							bc_on_step:
							begin
								release_iso_bc <= io_release;
								state          <= active;
							end
							rst_off_step:
							begin
								release_rst <= io_hold;
								state       <= clk_off_step;
							end
							clk_off_step:
							begin
								release_clk <= io_hold;
								state       <= pwr_off_step;
							end
							pwr_off_step:
							begin
								power_on <= io_hold;
								state    <= iso_off_step;
							end
							default:
							begin
								iso_sleep <= io_hold;
								state     <= asleep;
							end
						endcase
					end
				end
			endcase
		end
	end

	// layer must never leave reset without a running clock
	a_rst_needs_clk: assert property (@(posedge clk) disable iff (!rst_n)
		release_rst |-> release_clk);

	// bus side talks to the layer only while it is powered
	a_iso_needs_pwr: assert property (@(posedge clk) disable iff (!rst_n)
		release_iso_bc |-> power_on);

endmodule

// File: mbus_regular_isolation.sv
/*
 * always-on isolation between bus controller and layer controller
 * must not sit in the gated domain; purely combinational, no latency
 * iso_sleep at io_hold forces everything toward the layer low
 */
module mbus_regular_isolation
	import mbus_pkg::*;
(
	input  logic  iso_sleep,
	input  logic  power_on,
	input  logic  release_clk,
	input  logic  release_rst,
	input  logic  release_iso_bc,
	// from the layer controller
	input  addr_t tx_addr,
	input  data_t tx_data,
	input  logic  tx_pend,
	input  logic  tx_req,
	input  logic  tx_priority,
	input  logic  rx_ack,
	input  logic  tx_resp_ack,
	// from the bus controller
	input  logic  tx_ack,
	input  addr_t rx_addr,
	input  data_t rx_data,
	input  logic  rx_req,
	input  logic  rx_fail,
	input  logic  rx_pend,
	input  logic  tx_fail,
	input  logic  tx_succ,
	// toward the layer controller
	output logic  power_on_lc,
	output logic  release_clk_lc,
	output logic  release_rst_lc,
	output logic  tx_ack_lc,
	output addr_t rx_addr_lc,
	output data_t rx_data_lc,
	output logic  rx_req_lc,
	output logic  rx_fail_lc,
	output logic  rx_pend_lc,
	output logic  tx_fail_lc,
	output logic  tx_succ_lc,
	// toward the bus controller
	output logic  release_iso_masked,
	output addr_t tx_addr_bc,
	output data_t tx_data_bc,
	output logic  tx_pend_bc,
	output logic  tx_req_bc,
	output logic  tx_priority_bc,
	output logic  rx_ack_bc,
	output logic  tx_resp_ack_bc
);

	always_comb
	begin
		if (iso_sleep == io_hold)
		begin
			power_on_lc        = io_hold;
			release_clk_lc     = io_hold;
			release_rst_lc     = io_hold;
			tx_ack_lc          = 1'b0;
			rx_addr_lc         = '0;
			rx_data_lc         = '0;
			rx_req_lc          = 1'b0;
			rx_fail_lc         = 1'b0;
			rx_pend_lc         = 1'b0;
			tx_fail_lc         = 1'b0;
			tx_succ_lc         = 1'b0;
			release_iso_masked = io_hold;	// keeps bus side shut as well
		end
		else
		begin
			power_on_lc        = power_on;
			release_clk_lc     = release_clk;
			release_rst_lc     = release_rst;
			tx_ack_lc          = tx_ack;
			rx_addr_lc         = rx_addr;
			rx_data_lc         = rx_data;
			rx_req_lc          = rx_req;
			rx_fail_lc         = rx_fail;
			rx_pend_lc         = rx_pend;
			tx_fail_lc         = tx_fail;
			tx_succ_lc         = tx_succ;
			release_iso_masked = release_iso_bc;
		end
	end

	// layer outputs float while unpowered, so they are blocked here
	always_comb
	begin
		if (release_iso_masked == io_hold)
		begin
			tx_addr_bc     = '0;
			tx_data_bc     = '0;
			tx_pend_bc     = 1'b0;
			tx_req_bc      = 1'b0;
			tx_priority_bc = 1'b0;
			rx_ack_bc      = 1'b0;
			tx_resp_ack_bc = 1'b0;
		end
		else
		begin
			tx_addr_bc     = tx_addr;
			tx_data_bc     = tx_data;
			tx_pend_bc     = tx_pend;
			tx_req_bc      = tx_req;
			tx_priority_bc = tx_priority;
			rx_ack_bc      = rx_ack;
			tx_resp_ack_bc = tx_resp_ack;
		end
	end

	// isolation is released first on wake and withdrawn last on sleep
	always_comb
	begin
		if (iso_sleep == io_hold)
			a_iso_first: assert (!(power_on || release_clk || release_rst || release_iso_bc));
	end

endmodule

// File: mbus_bus_ctrl.sv
/*
 * simplified bus controller with strobes instead of the serial wire
 * holds one transmit and one receive message; single-word messages only
 * a transmit result stays up until the layer acknowledges it
 */
module mbus_bus_ctrl
	import mbus_pkg::*;
#(
	parameter addr_t LAYER_ADDR = 8'h5a,
	parameter int    RX_TIMEOUT = 8
)(
	input  logic  clk,
	input  logic  rst_n,
	input  addr_t tx_addr,
	input  data_t tx_data,
	input  logic  tx_req,
	input  logic  tx_priority,
	output logic  tx_ack,
	output logic  tx_succ,
	output logic  tx_fail,
	input  logic  tx_resp_ack,
	output addr_t rx_addr,
	output data_t rx_data,
	output logic  rx_req,
	output logic  rx_fail,
	output logic  rx_pend,
	input  logic  rx_ack,
	output logic  bus_tx_valid,
	output addr_t bus_tx_addr,
	output data_t bus_tx_data,
	output logic  bus_tx_priority,
	input  logic  bus_tx_done,
	input  logic  bus_tx_ok,
	input  logic  bus_rx_valid,
	input  addr_t bus_rx_addr,
	input  data_t bus_rx_data,
	output logic  bus_rx_lost
);

	localparam int TMO_W = $clog2(RX_TIMEOUT + 1);

	typedef enum logic [1:0] {tx_idle, tx_on_bus, tx_refused, tx_result} tx_state_t;
	typedef enum logic [1:0] {rx_idle, rx_offer, rx_release} rx_state_t;

	tx_state_t tx_state;
	rx_state_t rx_state;
	logic [TMO_W-1:0] rx_wait;
	logic rx_match;
	logic lost_since;	// something was dropped before the held message

	assign rx_match = bus_rx_valid && (bus_rx_addr == LAYER_ADDR || bus_rx_addr == '0);
	assign rx_pend  = 1'b0;	// no multi-word messages

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			tx_state     <= tx_idle;
			tx_ack       <= 1'b0;
			tx_succ      <= 1'b0;
			tx_fail      <= 1'b0;
			bus_tx_valid <= 1'b0;
		end
		else
		begin
			tx_ack       <= 1'b0;
			bus_tx_valid <= 1'b0;
			case (tx_state)
				tx_idle:
					if (tx_req)
					begin
						tx_ack <= 1'b1;
						if (tx_addr == LAYER_ADDR)
							tx_state <= tx_refused;	// never send to ourselves
						else
						begin
							bus_tx_valid <= 1'b1;
							tx_state     <= tx_on_bus;
						end
					end
				tx_on_bus:
					if (bus_tx_done)
					begin
						tx_succ  <= bus_tx_ok;
						tx_fail  <= !bus_tx_ok;
						tx_state <= tx_result;
					end
				tx_refused:
				begin
					tx_fail  <= 1'b1;
					tx_state <= tx_result;
				end
				default:
					if (tx_resp_ack)
					begin
						tx_succ  <= 1'b0;
						tx_fail  <= 1'b0;
						tx_state <= tx_idle;
					end
			endcase
		end
	end

	// bus payload copy, only meaningful with bus_tx_valid
	always_ff @(posedge clk)
	begin
		if (tx_state == tx_idle && tx_req)
		begin
			bus_tx_addr     <= tx_addr;
			bus_tx_data     <= tx_data;
			bus_tx_priority <= tx_priority;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rx_state    <= rx_idle;
			rx_req      <= 1'b0;
			rx_fail     <= 1'b0;
			rx_wait     <= '0;
			lost_since  <= 1'b0;
			bus_rx_lost <= 1'b0;
		end
		else
		begin
			bus_rx_lost <= 1'b0;
			if (rx_match && rx_state != rx_idle)
			begin
				bus_rx_lost <= 1'b1;	// back-pressure drop
				lost_since  <= 1'b1;
			end
			case (rx_state)
				rx_idle:
					if (rx_match)
					begin
						rx_req     <= 1'b1;
						rx_fail    <= lost_since;
						lost_since <= 1'b0;
						rx_wait    <= '0;
						rx_state   <= rx_offer;
					end
				rx_offer:
					if (rx_ack)
					begin
						rx_req   <= 1'b0;
						rx_state <= rx_release;
					end
					else if (rx_wait == TMO_W'(RX_TIMEOUT - 1))
					begin
						rx_req      <= 1'b0;
						bus_rx_lost <= 1'b1;
						lost_since  <= 1'b1;
						rx_state    <= rx_idle;
					end
					else
						rx_wait <= rx_wait + 1'b1;
				default:
					if (!rx_ack)
						rx_state <= rx_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (rx_state == rx_idle && rx_match)
		begin
			rx_addr <= bus_rx_addr;
			rx_data <= bus_rx_data;
		end
	end

	a_one_result: assert property (@(posedge clk) disable iff (!rst_n)
		!(tx_succ && tx_fail));

endmodule

// File: mbus_layer_ctrl.sv
/*
 * power-gated layer controller, one command in flight at a time
 * advances only on cycles with clk_en high (gated clock model)
 * all state clears while rst_release is low
 */
module mbus_layer_ctrl
	import mbus_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  clk_en,
	input  logic  rst_release,
	output addr_t tx_addr,
	output data_t tx_data,
	output logic  tx_pend,
	output logic  tx_req,
	output logic  tx_priority,
	input  logic  tx_ack,
	input  logic  tx_succ,
	input  logic  tx_fail,
	output logic  tx_resp_ack,
	input  addr_t rx_addr,
	input  data_t rx_data,
	input  logic  rx_req,
	input  logic  rx_fail,
	output logic  rx_ack,
	input  logic  cmd_valid,
	input  addr_t cmd_addr,
	input  data_t cmd_data,
	input  logic  cmd_pend,
	input  logic  cmd_priority,
	output logic  cmd_busy,
	output logic  cmd_done,
	output logic  cmd_ok,
	output logic  usr_rx_valid,
	output addr_t usr_rx_addr,
	output data_t usr_rx_data,
	output logic  usr_rx_fail
);

	typedef enum logic [1:0] {lc_idle, lc_request, lc_wait_result, lc_respond} lc_state_t;

	lc_state_t tx_state;

	assign cmd_busy = (tx_state != lc_idle);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			tx_state    <= lc_idle;
			tx_req      <= 1'b0;
			tx_resp_ack <= 1'b0;
			cmd_done    <= 1'b0;
			cmd_ok      <= 1'b0;
		end
		else if (!rst_release)
		begin
			tx_state    <= lc_idle;
			tx_req      <= 1'b0;
			tx_resp_ack <= 1'b0;
			cmd_done    <= 1'b0;
			cmd_ok      <= 1'b0;
		end
		else if (clk_en)
		begin
			cmd_done <= 1'b0;
			case (tx_state)
				lc_idle:
					if (cmd_valid)
					begin
						tx_req   <= 1'b1;
						tx_state <= lc_request;
					end
				lc_request:
					if (tx_ack)
					begin
						tx_req   <= 1'b0;
						tx_state <= lc_wait_result;
					end
				lc_wait_result:
					if (tx_succ || tx_fail)
					begin
						tx_resp_ack <= 1'b1;
						cmd_done    <= 1'b1;
						cmd_ok      <= tx_succ;
						tx_state    <= lc_respond;
					end
				default:
				begin
					tx_resp_ack <= 1'b0;	// one cycle is enough for the bus side
					tx_state    <= lc_idle;
				end
			endcase
		end
	end

	// payload held stable through the request
	always_ff @(posedge clk)
	begin
		if (clk_en && tx_state == lc_idle && cmd_valid)
		begin
			tx_addr     <= cmd_addr;
			tx_data     <= cmd_data;
			tx_pend     <= cmd_pend;
			tx_priority <= cmd_priority;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rx_ack       <= 1'b0;
			usr_rx_valid <= 1'b0;
		end
		else if (!rst_release)
		begin
			rx_ack       <= 1'b0;
			usr_rx_valid <= 1'b0;
		end
		else if (clk_en)
		begin
			usr_rx_valid <= rx_req && !rx_ack;	// new message, ack right away
			rx_ack       <= rx_req;
		end
	end

	always_ff @(posedge clk)
	begin
		if (clk_en && rx_req && !rx_ack)
		begin
			usr_rx_addr <= rx_addr;
			usr_rx_data <= rx_data;
			usr_rx_fail <= rx_fail;
		end
	end

endmodule

// File: mbus_layer_top.sv
/*
 * one power-gated layer with its always-on boundary
 * bus is modelled by strobes; power switch and pend bits are not modelled
 */
module mbus_layer_top
	import mbus_pkg::*;
#(
	parameter int    STEP_CYCLES = 2,
	parameter addr_t LAYER_ADDR  = 8'h5a,
	parameter int    RX_TIMEOUT  = 8
)(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  wake_req,
	input  logic  sleep_req,
	output logic  layer_active,
	input  logic  cmd_valid,
	input  addr_t cmd_addr,
	input  data_t cmd_data,
	input  logic  cmd_pend,
	input  logic  cmd_priority,
	output logic  cmd_busy,
	output logic  cmd_done,
	output logic  cmd_ok,
	output logic  usr_rx_valid,
	output addr_t usr_rx_addr,
	output data_t usr_rx_data,
	output logic  usr_rx_fail,
	output logic  bus_tx_valid,
	output addr_t bus_tx_addr,
	output data_t bus_tx_data,
	output logic  bus_tx_priority,
	input  logic  bus_tx_done,
	input  logic  bus_tx_ok,
	input  logic  bus_rx_valid,
	input  addr_t bus_rx_addr,
	input  data_t bus_rx_data,
	output logic  bus_rx_lost
);

	logic iso_sleep, power_on, release_clk, release_rst, release_iso_bc;
	logic release_clk_lc, release_rst_lc;
	addr_t tx_addr, tx_addr_bc, rx_addr, rx_addr_lc;
	data_t tx_data, tx_data_bc, rx_data, rx_data_lc;
	logic tx_pend, tx_req, tx_priority, rx_ack, tx_resp_ack;
	logic tx_req_bc, tx_priority_bc, rx_ack_bc, tx_resp_ack_bc;
	logic tx_ack, rx_req, rx_fail, rx_pend, tx_fail, tx_succ;
	logic tx_ack_lc, rx_req_lc, rx_fail_lc, tx_fail_lc, tx_succ_lc;

	mbus_power_seq #(.STEP_CYCLES(STEP_CYCLES)) u_seq (
		.clk(clk), .rst_n(rst_n), .wake_req(wake_req), .sleep_req(sleep_req),
		.iso_sleep(iso_sleep), .power_on(power_on), .release_clk(release_clk),
		.release_rst(release_rst), .release_iso_bc(release_iso_bc),
		.layer_active(layer_active)
	);

	mbus_regular_isolation u_iso (
		.iso_sleep(iso_sleep), .power_on(power_on), .release_clk(release_clk),
		.release_rst(release_rst), .release_iso_bc(release_iso_bc),
		.tx_addr(tx_addr), .tx_data(tx_data), .tx_pend(tx_pend), .tx_req(tx_req),
		.tx_priority(tx_priority), .rx_ack(rx_ack), .tx_resp_ack(tx_resp_ack),
		.tx_ack(tx_ack), .rx_addr(rx_addr), .rx_data(rx_data), .rx_req(rx_req),
		.rx_fail(rx_fail), .rx_pend(rx_pend), .tx_fail(tx_fail), .tx_succ(tx_succ),
		.power_on_lc(), .release_clk_lc(release_clk_lc), .release_rst_lc(release_rst_lc),
		.tx_ack_lc(tx_ack_lc), .rx_addr_lc(rx_addr_lc), .rx_data_lc(rx_data_lc),
		.rx_req_lc(rx_req_lc), .rx_fail_lc(rx_fail_lc), .rx_pend_lc(),
		.tx_fail_lc(tx_fail_lc), .tx_succ_lc(tx_succ_lc),
		.release_iso_masked(), .tx_addr_bc(tx_addr_bc),
		.tx_data_bc(tx_data_bc), .tx_pend_bc(), .tx_req_bc(tx_req_bc),
		.tx_priority_bc(tx_priority_bc), .rx_ack_bc(rx_ack_bc),
		.tx_resp_ack_bc(tx_resp_ack_bc)
	);

	mbus_bus_ctrl #(.LAYER_ADDR(LAYER_ADDR), .RX_TIMEOUT(RX_TIMEOUT)) u_bc (
		.clk(clk), .rst_n(rst_n), .tx_addr(tx_addr_bc), .tx_data(tx_data_bc),
		.tx_req(tx_req_bc), .tx_priority(tx_priority_bc), .tx_ack(tx_ack),
		.tx_succ(tx_succ), .tx_fail(tx_fail), .tx_resp_ack(tx_resp_ack_bc),
		.rx_addr(rx_addr), .rx_data(rx_data), .rx_req(rx_req), .rx_fail(rx_fail),
		.rx_pend(rx_pend), .rx_ack(rx_ack_bc), .bus_tx_valid(bus_tx_valid),
		.bus_tx_addr(bus_tx_addr), .bus_tx_data(bus_tx_data),
		.bus_tx_priority(bus_tx_priority), .bus_tx_done(bus_tx_done),
		.bus_tx_ok(bus_tx_ok), .bus_rx_valid(bus_rx_valid), .bus_rx_addr(bus_rx_addr),
		.bus_rx_data(bus_rx_data), .bus_rx_lost(bus_rx_lost)
	);

	mbus_layer_ctrl u_lc (
		.clk(clk), .rst_n(rst_n), .clk_en(release_clk_lc), .rst_release(release_rst_lc),
		.tx_addr(tx_addr), .tx_data(tx_data), .tx_pend(tx_pend), .tx_req(tx_req),
		.tx_priority(tx_priority), .tx_ack(tx_ack_lc), .tx_succ(tx_succ_lc),
		.tx_fail(tx_fail_lc), .tx_resp_ack(tx_resp_ack), .rx_addr(rx_addr_lc),
		.rx_data(rx_data_lc), .rx_req(rx_req_lc), .rx_fail(rx_fail_lc), .rx_ack(rx_ack),
		.cmd_valid(cmd_valid), .cmd_addr(cmd_addr), .cmd_data(cmd_data),
		.cmd_pend(cmd_pend), .cmd_priority(cmd_priority), .cmd_busy(cmd_busy),
		.cmd_done(cmd_done), .cmd_ok(cmd_ok), .usr_rx_valid(usr_rx_valid),
		.usr_rx_addr(usr_rx_addr), .usr_rx_data(usr_rx_data), .usr_rx_fail(usr_rx_fail)
	);

endmodule

// File: tb_mbus_layer.sv
/*
 * random testbench for mbus_layer_top, fixed seed
 * the bus environment answers bus_tx_valid with bus_tx_done after 0 to 3 cycles
 * received messages are spaced so that the awake layer never sees back-pressure
 */
module tb_mbus_layer
	import mbus_pkg::*;
();

	localparam int    STEP_CYCLES = 2;
	localparam addr_t LAYER_ADDR  = 8'h5a;
	localparam int    RX_TIMEOUT  = 8;
	localparam int    WAIT_LIMIT  = 200;	// longest any single wait may take

	logic  clk, rst_n, wake_req, sleep_req, layer_active;
	logic  cmd_valid, cmd_pend, cmd_priority, cmd_busy, cmd_done, cmd_ok;
	addr_t cmd_addr, usr_rx_addr, bus_tx_addr, bus_rx_addr;
	data_t cmd_data, usr_rx_data, bus_tx_data, bus_rx_data;
	logic  usr_rx_valid, usr_rx_fail;
	logic  bus_tx_valid, bus_tx_priority, bus_tx_done, bus_tx_ok, bus_rx_valid, bus_rx_lost;

	integer seed;
	int     errors;
	int     checks;
	addr_t  exp_rx_addr[$];	// messages the layer must hand to the user
	data_t  exp_rx_data[$];

	mbus_layer_top #(
		.STEP_CYCLES(STEP_CYCLES),
		.LAYER_ADDR(LAYER_ADDR),
		.RX_TIMEOUT(RX_TIMEOUT)
	) dut (
		.clk(clk), .rst_n(rst_n), .wake_req(wake_req), .sleep_req(sleep_req),
		.layer_active(layer_active), .cmd_valid(cmd_valid), .cmd_addr(cmd_addr),
		.cmd_data(cmd_data), .cmd_pend(cmd_pend), .cmd_priority(cmd_priority),
		.cmd_busy(cmd_busy), .cmd_done(cmd_done), .cmd_ok(cmd_ok),
		.usr_rx_valid(usr_rx_valid), .usr_rx_addr(usr_rx_addr), .usr_rx_data(usr_rx_data),
		.usr_rx_fail(usr_rx_fail), .bus_tx_valid(bus_tx_valid), .bus_tx_addr(bus_tx_addr),
		.bus_tx_data(bus_tx_data), .bus_tx_priority(bus_tx_priority),
		.bus_tx_done(bus_tx_done), .bus_tx_ok(bus_tx_ok), .bus_rx_valid(bus_rx_valid),
		.bus_rx_addr(bus_rx_addr), .bus_rx_data(bus_rx_data), .bus_rx_lost(bus_rx_lost)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial
	begin
		repeat (20000) @(posedge clk);
		$display("simulation ran too long, watchdog expired");
		$display("Test failed");
		$finish;
	end

	task automatic step();
		@(posedge clk);
		#2;	// drive and sample clear of the edge
	endtask

	function automatic logic [31:0] next_rand();
		next_rand = $random(seed);
	endfunction

	// own address and broadcast address 0 reach the layer
	function automatic logic rx_for_layer(input addr_t a);
		rx_for_layer = (a == LAYER_ADDR) || (a == 8'h00);
	endfunction

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_data(input string name, input data_t got, input data_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic report_fault(input string what);
		errors++;
		$display("%s", what);
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (errors == errors_before)
			$display("%s: pass", name);
		else
			$display("%s: %0d error(s)", name, errors - errors_before);
	endtask

	task automatic wake_layer(input bit with_commands);
		logic [31:0] r;
		int n;
		wake_req = 1'b1;
		step();
		wake_req = 1'b0;
		n = 0;
		while (!layer_active && n < WAIT_LIMIT)
		begin
			r = next_rand();
			cmd_valid = with_commands && r[0] && (n < 3 * STEP_CYCLES);	// layer still in reset
			cmd_addr = r[15:8];
			cmd_data = next_rand();
			step();
			n++;
			if (bus_tx_valid)
				report_fault("bus_tx_valid seen while the layer was still waking up");
		end
		cmd_valid = 1'b0;
		if (!layer_active)
			report_fault("layer_active never rose after wake_req");
		else if (n != 5 * STEP_CYCLES)
			report_fault($sformatf("layer_active rose after %0d cycles instead of %0d",
				n, 5 * STEP_CYCLES));
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (cmd_busy && n < WAIT_LIMIT)
		begin
			step();
			n++;
		end
		if (cmd_busy)
			report_fault("layer stayed busy, no command could be issued");
	endtask

	task automatic run_transfer(input addr_t a, input data_t d, input logic prio);
		logic [31:0] r;
		logic exp_bus;
		logic exp_ok;
		bit sent;
		int n;
		r = next_rand();
		exp_bus = (a != LAYER_ADDR);	// own address is refused
		exp_ok = exp_bus && r[0];
		sent = 0;
		wait_idle();
		cmd_valid = 1'b1;
		cmd_addr = a;
		cmd_data = d;
		cmd_pend = r[1];
		cmd_priority = prio;
		step();
		cmd_valid = 1'b0;
		check_bit("cmd_busy", cmd_busy, 1'b1);	// command taken
		n = 0;
		while (!cmd_done && n < WAIT_LIMIT)
		begin
			step();
			n++;
			if (bus_tx_valid)
			begin
				if (!exp_bus || sent)
					report_fault("unexpected bus_tx_valid for this command");
				else
				begin
					check_addr("bus_tx_addr", bus_tx_addr, a);
					check_data("bus_tx_data", bus_tx_data, d);
					check_bit("bus_tx_priority", bus_tx_priority, prio);
				end
				sent = 1;
				repeat (r[3:2]) step();
				bus_tx_done = 1'b1;
				bus_tx_ok = r[0];
				step();
				bus_tx_done = 1'b0;
				bus_tx_ok = 1'b0;
			end
		end
		if (!cmd_done)
			report_fault("cmd_done never came for the command");
		else
			check_bit("cmd_ok", cmd_ok, exp_ok);
		if (exp_bus && !sent)
			report_fault("command never reached the bus");
	endtask

	// steps a fixed number of cycles while matching usr_rx_valid to the model
	task automatic watch_rx(input int cycles);
		int i;
		for (i = 0; i < cycles; i++)
		begin
			step();
			if (usr_rx_valid)
			begin
				if (exp_rx_addr.size() == 0)
					report_fault("usr_rx_valid without a matching bus message");
				else
				begin
					check_addr("usr_rx_addr", usr_rx_addr, exp_rx_addr.pop_front());
					check_data("usr_rx_data", usr_rx_data, exp_rx_data.pop_front());
					check_bit("usr_rx_fail", usr_rx_fail, 1'b0);
				end
			end
			if (bus_rx_lost)
				report_fault("bus_rx_lost while the layer was awake");
		end
	endtask

	task automatic send_rx(input addr_t a, input data_t d);
		bus_rx_valid = 1'b1;
		bus_rx_addr = a;
		bus_rx_data = d;
		if (rx_for_layer(a))
		begin
			exp_rx_addr.push_back(a);
			exp_rx_data.push_back(d);
		end
		step();
		bus_rx_valid = 1'b0;
	endtask

	initial
	begin
		int e;
		int i;
		int n;
		bit lost;
		logic [31:0] r;
		addr_t a;
		seed = 32'h2ef5;
		errors = 0;
		checks = 0;
		rst_n = 1'b0;
		wake_req = 1'b0;
		sleep_req = 1'b0;
		cmd_valid = 1'b0;
		cmd_addr = '0;
		cmd_data = '0;
		cmd_pend = 1'b0;
		cmd_priority = 1'b0;
		bus_tx_done = 1'b0;
		bus_tx_ok = 1'b0;
		bus_rx_valid = 1'b0;
		bus_rx_addr = '0;
		bus_rx_data = '0;
		repeat (10) @(posedge clk);
		#2;
		rst_n = 1'b1;
		step();

		e = errors;
		wake_layer(1'b1);
		report_test("wake", e);

		e = errors;
		for (i = 0; i < 20; i++)
		begin
			r = next_rand();
			a = r[7:0];
			if (a == LAYER_ADDR)
				a = a ^ 8'h01;
			run_transfer(a, next_rand(), r[8]);
		end
		report_test("transmit", e);

		e = errors;
		for (i = 0; i < 4; i++)
		begin
			r = next_rand();
			run_transfer(LAYER_ADDR, next_rand(), r[0]);
		end
		report_test("self address refusal", e);

		e = errors;
		for (i = 0; i < 30; i++)
		begin
			r = next_rand();
			case (r[1:0])
				2'd0: a = LAYER_ADDR;
				2'd1: a = 8'h00;
				default: a = r[15:8];
			endcase
			send_rx(a, next_rand());
			watch_rx(5 + int'(r[3:2]));	// bus side idle again before the next one
		end
		n = 0;
		while (exp_rx_addr.size() != 0 && n < WAIT_LIMIT)
		begin
			watch_rx(1);
			n++;
		end
		if (exp_rx_addr.size() != 0)
			report_fault("some filtered messages never reached the user");
		report_test("receive filter", e);

		e = errors;
		sleep_req = 1'b1;
		step();
		sleep_req = 1'b0;
		n = 1;
		while (layer_active && n < WAIT_LIMIT)
		begin
			step();
			n++;
		end
		if (layer_active)
			report_fault("layer_active never fell after sleep_req");
		else if (n != 1)
			report_fault("layer_active did not fall one cycle after sleep_req");
		for (i = 0; i < 5 * STEP_CYCLES + 2; i++)
			step();	// sequencer walks down to asleep
		bus_rx_valid = 1'b1;
		bus_rx_addr = LAYER_ADDR;
		bus_rx_data = next_rand();
		step();
		bus_rx_valid = 1'b0;
		lost = 0;
		n = 0;
		while (!lost && n < RX_TIMEOUT + 10)
		begin
			step();
			n++;
			if (usr_rx_valid)
				report_fault("sleeping layer handed a message to the user");
			if (bus_rx_lost)
				lost = 1;
		end
		if (!lost)
			report_fault("no bus_rx_lost for a message sent to the sleeping layer");
		report_test("sleep", e);

		e = errors;
		wake_layer(1'b0);
		for (i = 0; i < 5; i++)
		begin
			r = next_rand();
			a = r[7:0];
			if (a == LAYER_ADDR)
				a = a ^ 8'h80;
			run_transfer(a, next_rand(), r[9]);
		end
		report_test("wake again", e);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: src.f
mbus_pkg.sv
mbus_power_seq.sv
mbus_regular_isolation.sv
mbus_bus_ctrl.sv
mbus_layer_ctrl.sv
mbus_layer_top.sv
tb_mbus_layer.sv

// File: run_sim.sh
#!/bin/bash
# build and run tb_mbus_layer with Verilator, then decide from the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f src.f --top-module tb_mbus_layer -o tb_sim \
	> build.log 2>&1 && ./obj_dir/tb_sim > sim.log 2>&1 || true

grep -q "Test completed successfully" sim.log 2>/dev/null && echo "simulation PASS" && exit 0
cat build.log sim.log 2>/dev/null
echo "simulation FAIL"
exit 1
